//--- Makefile
# Verilator build, run and lint for the decode/execute subsystem

VERILATOR  ?= verilator
TOP        ?= tb_decode_execute
RTL_TOP    ?= decode_execute_top
FILELIST   ?= decode_execute.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "Test OK" $(LOG); then \
		echo "No pass message in $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- decode_execute.f
design/rv_core_pkg.sv
design/instr_decoder.sv
design/reg_file.sv
design/execute_register.sv
design/execute_stage.sv
design/decode_execute_top.sv
dv/tb_decode_execute.sv

//--- design/decode_execute_top.sv
`timescale 1ns/100ps
`default_nettype none

module decode_execute_top (
    input  logic                               clk,
    input  logic                               arst_n_i,
    input  logic [rv_core_pkg::xlen-1:0]       instr_i,
    input  logic [rv_core_pkg::xlen-1:0]       pc_i,
    input  logic                               valid_i,
    input  logic                               stall_i,
    input  logic                               flush_i,
    input  logic                               wb_we_i,
    input  logic [rv_core_pkg::reg_addr_w-1:0] wb_rd_i,
    input  logic [rv_core_pkg::xlen-1:0]       wb_data_i,
    output logic [rv_core_pkg::xlen-1:0]       alu_result_o,
    output logic [rv_core_pkg::xlen-1:0]       store_data_o,
    output logic [rv_core_pkg::reg_addr_w-1:0] rd_o,
    output logic                               reg_write_o,
    output logic                               mem_write_o,
    output rv_core_pkg::result_src_e           result_src_o,
    output logic                               byte_op_o,
    output logic                               branch_taken_o,
    output logic [rv_core_pkg::xlen-1:0]       target_o,
    output logic                               illegal_o
);

    import rv_core_pkg::*;

    logic [xlen-1:0]       rd1_d, rd2_d, imm_d, pc_plus4_d;
    logic [reg_addr_w-1:0] rs1_d, rs2_d, rd_d;
    alu_op_e               alu_op_d;
    result_src_e           result_src_d;
    logic [2:0]            funct3_d;
    logic                  reg_write_d, mem_write_d, branch_d, jump_d, jalr_d;
    logic                  alu_src_d, pc_src_a_d, byte_op_d, illegal_d;

    logic [xlen-1:0]       rd1_e, rd2_e, imm_e, pc_e, pc_plus4_e;
    logic [reg_addr_w-1:0] rs1_e, rs2_e;
    alu_op_e               alu_op_ex;
    logic [2:0]            funct3_e;
    logic                  branch_e, jump_e, jalr_e, alu_src_e, pc_src_a_e;

    assign pc_plus4_d = pc_i + 32'd4;

    instr_decoder u_decoder (
        .instr_i(instr_i), .rs1_o(rs1_d), .rs2_o(rs2_d), .rd_o(rd_d), .imm_o(imm_d),
        .alu_op_o(alu_op_d), .result_src_o(result_src_d), .funct3_o(funct3_d),
        .reg_write_o(reg_write_d), .mem_write_o(mem_write_d), .branch_o(branch_d),
        .jump_o(jump_d), .jalr_o(jalr_d), .alu_src_o(alu_src_d), .pc_src_a_o(pc_src_a_d),
        .byte_op_o(byte_op_d), .illegal_o(illegal_d)
    );

    reg_file u_reg_file (
        .clk(clk), .arst_n_i(arst_n_i), .we_i(wb_we_i), .waddr_i(wb_rd_i),
        .raddr1_i(rs1_d), .raddr2_i(rs2_d), .wdata_i(wb_data_i),
        .rdata1_o(rd1_d), .rdata2_o(rd2_d)
    );

    execute_register u_execute_register (
        .clk(clk), .arst_n_i(arst_n_i), .valid_i(valid_i), .stall_i(stall_i), .flush_i(flush_i),
        .rd1_d_i(rd1_d), .rd2_d_i(rd2_d), .imm_d_i(imm_d), .pc_d_i(pc_i),
        .pc_plus4_d_i(pc_plus4_d), .rs1_d_i(rs1_d), .rs2_d_i(rs2_d), .rd_d_i(rd_d),
        .alu_op_d_i(alu_op_d), .result_src_d_i(result_src_d), .funct3_d_i(funct3_d),
        .reg_write_d_i(reg_write_d), .mem_write_d_i(mem_write_d), .branch_d_i(branch_d),
        .jump_d_i(jump_d), .jalr_d_i(jalr_d), .alu_src_d_i(alu_src_d),
        .pc_src_a_d_i(pc_src_a_d), .byte_op_d_i(byte_op_d), .illegal_d_i(illegal_d),
        .rd1_e_o(rd1_e), .rd2_e_o(rd2_e), .imm_e_o(imm_e), .pc_e_o(pc_e),
        .pc_plus4_e_o(pc_plus4_e), .rs1_e_o(rs1_e), .rs2_e_o(rs2_e), .rd_e_o(rd_o),
        .alu_op_e_o(alu_op_ex), .result_src_e_o(result_src_o), .funct3_e_o(funct3_e),
        .reg_write_e_o(reg_write_o), .mem_write_e_o(mem_write_o), .branch_e_o(branch_e),
        .jump_e_o(jump_e), .jalr_e_o(jalr_e), .alu_src_e_o(alu_src_e),
        .pc_src_a_e_o(pc_src_a_e), .byte_op_e_o(byte_op_o), .illegal_e_o(illegal_o)
    );

    execute_stage u_execute_stage (
        .rd1_e_i(rd1_e), .rd2_e_i(rd2_e), .imm_e_i(imm_e), .pc_e_i(pc_e),
        .pc_plus4_e_i(pc_plus4_e), .rs1_e_i(rs1_e), .rs2_e_i(rs2_e),
        .alu_op_e_i(alu_op_ex), .result_src_e_i(result_src_o), .funct3_e_i(funct3_e),
        .branch_e_i(branch_e), .jump_e_i(jump_e), .jalr_e_i(jalr_e),
        .alu_src_e_i(alu_src_e), .pc_src_a_e_i(pc_src_a_e),
        .wb_we_i(wb_we_i), .wb_rd_i(wb_rd_i), .wb_data_i(wb_data_i),
        .alu_result_o(alu_result_o), .store_data_o(store_data_o), .target_o(target_o),
        .branch_taken_o(branch_taken_o)
    );

endmodule

`default_nettype wire

//--- design/execute_register.sv
`timescale 1ns/100ps
`default_nettype none

module execute_register (
    input  logic                               clk,
    input  logic                               arst_n_i,
    input  logic                               valid_i,
    input  logic                               stall_i,
    input  logic                               flush_i,
    input  logic [rv_core_pkg::xlen-1:0]       rd1_d_i, rd2_d_i, imm_d_i, pc_d_i, pc_plus4_d_i,
    input  logic [rv_core_pkg::reg_addr_w-1:0] rs1_d_i, rs2_d_i, rd_d_i,
    input  rv_core_pkg::alu_op_e               alu_op_d_i,
    input  rv_core_pkg::result_src_e           result_src_d_i,
    input  logic [2:0]                         funct3_d_i,
    input  logic                               reg_write_d_i, mem_write_d_i, branch_d_i,
    input  logic                               jump_d_i, jalr_d_i, alu_src_d_i,
    input  logic                               pc_src_a_d_i, byte_op_d_i, illegal_d_i,
    output logic [rv_core_pkg::xlen-1:0]       rd1_e_o, rd2_e_o, imm_e_o, pc_e_o, pc_plus4_e_o,
    output logic [rv_core_pkg::reg_addr_w-1:0] rs1_e_o, rs2_e_o, rd_e_o,
    output rv_core_pkg::alu_op_e               alu_op_e_o,
    output rv_core_pkg::result_src_e           result_src_e_o,
    output logic [2:0]                         funct3_e_o,
    output logic                               reg_write_e_o, mem_write_e_o, branch_e_o,
    output logic                               jump_e_o, jalr_e_o, alu_src_e_o,
    output logic                               pc_src_a_e_o, byte_op_e_o, illegal_e_o
);

    import rv_core_pkg::*;

    logic take;  // Real instruction, not a bubble

    assign take = valid_i && !flush_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd1_e_o        <= '0;
            rd2_e_o        <= '0;
            imm_e_o        <= '0;
            pc_e_o         <= '0;
            pc_plus4_e_o   <= '0;
            rs1_e_o        <= '0;
            rs2_e_o        <= '0;
            rd_e_o         <= '0;
            alu_op_e_o     <= alu_add;
            result_src_e_o <= res_alu;
            funct3_e_o     <= '0;
            reg_write_e_o  <= 1'b0;
            mem_write_e_o  <= 1'b0;
            branch_e_o     <= 1'b0;
            jump_e_o       <= 1'b0;
            jalr_e_o       <= 1'b0;
            alu_src_e_o    <= 1'b0;
            pc_src_a_e_o   <= 1'b0;
            byte_op_e_o    <= 1'b0;
            illegal_e_o    <= 1'b0;
        end else if (flush_i || !stall_i) begin  // Flush overrides stall
            rd1_e_o        <= rd1_d_i;
            rd2_e_o        <= rd2_d_i;
            imm_e_o        <= imm_d_i;
            pc_e_o         <= pc_d_i;
            pc_plus4_e_o   <= pc_plus4_d_i;
            rs1_e_o        <= rs1_d_i;
            rs2_e_o        <= rs2_d_i;
            rd_e_o         <= rd_d_i;
            alu_op_e_o     <= alu_op_d_i;
            result_src_e_o <= result_src_d_i;
            funct3_e_o     <= funct3_d_i;
            reg_write_e_o  <= reg_write_d_i && take;
            mem_write_e_o  <= mem_write_d_i && take;
            branch_e_o     <= branch_d_i && take;
            jump_e_o       <= jump_d_i && take;
            jalr_e_o       <= jalr_d_i && take;
            alu_src_e_o    <= alu_src_d_i;
            pc_src_a_e_o   <= pc_src_a_d_i;
            byte_op_e_o    <= byte_op_d_i;
            illegal_e_o    <= illegal_d_i && take;
        end
    end

endmodule

`default_nettype wire

//--- design/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  logic [rv_core_pkg::xlen-1:0]       rd1_e_i, rd2_e_i, imm_e_i, pc_e_i, pc_plus4_e_i,
    input  logic [rv_core_pkg::reg_addr_w-1:0] rs1_e_i, rs2_e_i,
    input  rv_core_pkg::alu_op_e               alu_op_e_i,
    input  rv_core_pkg::result_src_e           result_src_e_i,
    input  logic [2:0]                         funct3_e_i,
    input  logic                               branch_e_i, jump_e_i, jalr_e_i,
    input  logic                               alu_src_e_i, pc_src_a_e_i,
    input  logic                               wb_we_i,
    input  logic [rv_core_pkg::reg_addr_w-1:0] wb_rd_i,
    input  logic [rv_core_pkg::xlen-1:0]       wb_data_i,
    output logic [rv_core_pkg::xlen-1:0]       alu_result_o,
    output logic [rv_core_pkg::xlen-1:0]       store_data_o,
    output logic [rv_core_pkg::xlen-1:0]       target_o,
    output logic                               branch_taken_o
);

    import rv_core_pkg::*;

    logic [xlen-1:0] src_a;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] jalr_sum;
    logic            cond;

    // Writeback landing while the instruction sits in execute
    assign src_a = (wb_we_i && wb_rd_i != '0 && wb_rd_i == rs1_e_i) ? wb_data_i : rd1_e_i;
    assign src_b = (wb_we_i && wb_rd_i != '0 && wb_rd_i == rs2_e_i) ? wb_data_i : rd2_e_i;

    assign op_a = pc_src_a_e_i ? pc_e_i : src_a;
    assign op_b = alu_src_e_i ? imm_e_i : src_b;

    always_comb begin
        case (alu_op_e_i)
            alu_add:    alu_out = op_a + op_b;
            alu_sub:    alu_out = op_a - op_b;
            alu_sll:    alu_out = op_a << op_b[4:0];
            alu_slt:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_out = {31'b0, op_a < op_b};
            alu_xor:    alu_out = op_a ^ op_b;
            alu_srl:    alu_out = op_a >> op_b[4:0];
            alu_sra:    alu_out = $signed(op_a) >>> op_b[4:0];
            alu_or:     alu_out = op_a | op_b;
            alu_and:    alu_out = op_a & op_b;
            alu_pass_b: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    always_comb begin
        case (funct3_e_i)
            3'b000:  cond = (src_a == src_b);                   // beq
            3'b001:  cond = (src_a != src_b);                   // bne
            3'b100:  cond = ($signed(src_a) < $signed(src_b));  // blt
            3'b101:  cond = ($signed(src_a) >= $signed(src_b)); // bge
            3'b110:  cond = (src_a < src_b);                    // bltu
            3'b111:  cond = (src_a >= src_b);                   // bgeu
            default: cond = 1'b0;
        endcase
    end

    assign jalr_sum       = src_a + imm_e_i;
    assign target_o       = jalr_e_i ? {jalr_sum[xlen-1:1], 1'b0} : pc_e_i + imm_e_i;
    assign branch_taken_o = jump_e_i || (branch_e_i && cond);
    assign store_data_o   = src_b;
    assign alu_result_o   = (result_src_e_i == res_pc_plus4) ? pc_plus4_e_i : alu_out;

endmodule

`default_nettype wire

//--- design/instr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
    input  logic [rv_core_pkg::xlen-1:0]       instr_i,
    output logic [rv_core_pkg::reg_addr_w-1:0] rs1_o,
    output logic [rv_core_pkg::reg_addr_w-1:0] rs2_o,
    output logic [rv_core_pkg::reg_addr_w-1:0] rd_o,
    output logic [rv_core_pkg::xlen-1:0]       imm_o,
    output rv_core_pkg::alu_op_e               alu_op_o,
    output rv_core_pkg::result_src_e           result_src_o,
    output logic [2:0]                         funct3_o,
    output logic                               reg_write_o,
    output logic                               mem_write_o,
    output logic                               branch_o,
    output logic                               jump_o,
    output logic                               jalr_o,
    output logic                               alu_src_o,
    output logic                               pc_src_a_o,
    output logic                               byte_op_o,
    output logic                               illegal_o
);

    import rv_core_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;

    // funct3 to ALU operation, alt selects sub/sra
    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode   = opcode_e'(instr_i[6:0]);
    assign funct3   = instr_i[14:12];
    assign funct3_o = funct3;
    assign rs1_o    = instr_i[19:15];
    assign rs2_o    = instr_i[24:20];
    assign rd_o     = instr_i[11:7];

    always_comb begin
        imm_o        = '0;
        alu_op_o     = alu_add;
        result_src_o = res_alu;
        reg_write_o  = 1'b0;
        mem_write_o  = 1'b0;
        branch_o     = 1'b0;
        jump_o       = 1'b0;
        jalr_o       = 1'b0;
        alu_src_o    = 1'b0;
        pc_src_a_o   = 1'b0;
        byte_op_o    = 1'b0;
        illegal_o    = 1'b0;
        case (opcode)
            opc_op: begin
                reg_write_o = 1'b1;
                alu_op_o    = alu_decode(funct3, instr_i[30]);
            end
            opc_op_imm: begin
                reg_write_o = 1'b1;
                alu_src_o   = 1'b1;
                imm_o       = {{20{instr_i[31]}}, instr_i[31:20]};
                alu_op_o    = alu_decode(funct3, instr_i[30] && funct3 == 3'b101);  // No subi
            end
            opc_load: begin
                reg_write_o  = 1'b1;
                alu_src_o    = 1'b1;
                result_src_o = res_mem;
                byte_op_o    = (funct3[1:0] == 2'b00);
                imm_o        = {{20{instr_i[31]}}, instr_i[31:20]};
            end
            opc_store: begin
                mem_write_o = 1'b1;
                alu_src_o   = 1'b1;
                byte_op_o   = (funct3[1:0] == 2'b00);
                imm_o       = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            end
            opc_branch: begin
                branch_o = 1'b1;
                alu_op_o = alu_sub;
                imm_o    = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                            instr_i[11:8], 1'b0};
            end
            opc_jal: begin
                reg_write_o  = 1'b1;
                jump_o       = 1'b1;
                result_src_o = res_pc_plus4;
                imm_o        = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                                instr_i[30:21], 1'b0};
            end
            opc_jalr: begin
                reg_write_o  = 1'b1;
                jump_o       = 1'b1;
                jalr_o       = 1'b1;
                alu_src_o    = 1'b1;
                result_src_o = res_pc_plus4;
                imm_o        = {{20{instr_i[31]}}, instr_i[31:20]};
            end
            opc_lui: begin
                reg_write_o = 1'b1;
                alu_src_o   = 1'b1;
                alu_op_o    = alu_pass_b;
                imm_o       = {instr_i[31:12], 12'b0};
            end
            opc_auipc: begin
                reg_write_o = 1'b1;
                alu_src_o   = 1'b1;
                pc_src_a_o  = 1'b1;  // PC + upper immediate
                imm_o       = {instr_i[31:12], 12'b0};
            end
            default: illegal_o = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                               clk,
    input  logic                               arst_n_i,
    input  logic                               we_i,
    input  logic [rv_core_pkg::reg_addr_w-1:0] waddr_i,
    input  logic [rv_core_pkg::reg_addr_w-1:0] raddr1_i,
    input  logic [rv_core_pkg::reg_addr_w-1:0] raddr2_i,
    input  logic [rv_core_pkg::xlen-1:0]       wdata_i,
    output logic [rv_core_pkg::xlen-1:0]       rdata1_o,
    output logic [rv_core_pkg::xlen-1:0]       rdata2_o
);

    import rv_core_pkg::*;

    logic [xlen-1:0] regs [1:31];  // x0 not stored

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Write-through so decode sees a same-cycle writeback
    assign rdata1_o = (raddr1_i == '0)                  ? '0      :
                      (we_i && raddr1_i == waddr_i)     ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0)                  ? '0      :
                      (we_i && raddr2_i == waddr_i)     ? wdata_i : regs[raddr2_i];

endmodule

`default_nettype wire

//--- design/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // RV32I major opcodes, bits [6:0]
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10  // LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        res_alu      = 2'd0,
        res_mem      = 2'd1,
        res_pc_plus4 = 2'd2  // Link value for jumps
    } result_src_e;

endpackage

`default_nettype wire

//--- dv/tb_decode_execute.sv
`timescale 1ns/100ps
`default_nettype none

module tb_decode_execute;

    import rv_core_pkg::*;

    localparam int n_alu          = 200;
    localparam int n_ctrl         = 150;
    localparam int stim_cycles    = 3 * (n_alu + n_ctrl) + 60;
    localparam int timeout_cycles = 2 * stim_cycles + 100;

    typedef struct packed {
        logic [31:0] alu;
        logic [31:0] target;
        logic [31:0] store_data;
        logic [4:0]  rd;
        logic [1:0]  res_src;
        logic        byte_op;
        logic        taken;
        logic        reg_write;
        logic        mem_write;
        logic        illegal;
        logic        use_alu;
        logic        use_target;
    } expect_t;

    logic        clk;
    logic        arst_n_i;
    logic [31:0] instr_i;
    logic [31:0] pc_i;
    logic        valid_i;
    logic        stall_i;
    logic        flush_i;
    logic        wb_we_i;
    logic [4:0]  wb_rd_i;
    logic [31:0] wb_data_i;
    logic [31:0] alu_result_o;
    logic [31:0] store_data_o;
    logic [4:0]  rd_o;
    logic        reg_write_o;
    logic        mem_write_o;
    result_src_e result_src_o;
    logic        byte_op_o;
    logic        branch_taken_o;
    logic [31:0] target_o;
    logic        illegal_o;

    logic [31:0] shadow [32];  // Register file as seen by the running instruction
    logic        live;         // Execute stage holds a real instruction
    logic [31:0] live_instr;
    logic [31:0] live_pc;
    int          n_checks = 0;
    int          n_errors = 0;
    int          cycles   = 0;

    decode_execute_top UUT (
        .clk(clk), .arst_n_i(arst_n_i), .instr_i(instr_i), .pc_i(pc_i), .valid_i(valid_i),
        .stall_i(stall_i), .flush_i(flush_i), .wb_we_i(wb_we_i), .wb_rd_i(wb_rd_i),
        .wb_data_i(wb_data_i), .alu_result_o(alu_result_o), .store_data_o(store_data_o),
        .rd_o(rd_o), .reg_write_o(reg_write_o), .mem_write_o(mem_write_o),
        .result_src_o(result_src_o), .byte_op_o(byte_op_o), .branch_taken_o(branch_taken_o),
        .target_o(target_o), .illegal_o(illegal_o)
    );

    always #4 clk = ~clk;

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        n_checks++;
        if (expected !== actual) begin
            n_errors++;
            $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    // RV32I integer operations, alt is instr[30]
    function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic expect_t ref_execute(input logic [31:0] instr, input logic [31:0] pc,
                                            input logic [31:0] regs [32]);
        expect_t     e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [2:0]  f3;
        a     = regs[instr[19:15]];
        b     = regs[instr[24:20]];
        f3    = instr[14:12];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_u = {instr[31:12], 12'h000};
        imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        e         = '0;
        e.rd      = instr[11:7];
        e.res_src = res_alu;
        case (instr[6:0])
            opc_op:     {e.reg_write, e.use_alu, e.alu} = {2'b11, alu_calc(f3, instr[30], a, b)};
            opc_op_imm: {e.reg_write, e.use_alu, e.alu} =
                            {2'b11, alu_calc(f3, instr[30] && f3 == 3'b101, a, imm_i)};
            opc_load: begin
                {e.reg_write, e.use_alu, e.alu} = {2'b11, a + imm_i};  // Address
                e.res_src = res_mem;
                e.byte_op = (f3[1:0] == 2'b00);
            end
            opc_store: begin
                {e.mem_write, e.use_alu, e.alu} = {2'b11, a + imm_s};
                e.store_data = b;
                e.byte_op    = (f3[1:0] == 2'b00);
            end
            opc_branch: begin
                e.use_target = 1'b1;
                e.target     = pc + imm_b;
                case (f3)
                    3'b000:  e.taken = (a == b);
                    3'b001:  e.taken = (a != b);
                    3'b100:  e.taken = ($signed(a) < $signed(b));
                    3'b101:  e.taken = ($signed(a) >= $signed(b));
                    3'b110:  e.taken = (a < b);
                    3'b111:  e.taken = (a >= b);
                    default: e.taken = 1'b0;
                endcase
            end
            opc_jal, opc_jalr: begin
                {e.reg_write, e.use_alu, e.use_target, e.taken} = 4'b1111;
                e.res_src = res_pc_plus4;
                e.alu     = pc + 32'd4;  // Link value
                e.target  = (instr[6:0] == opc_jal) ? pc + imm_j : (a + imm_i) & ~32'd1;
            end
            opc_lui:    {e.reg_write, e.use_alu, e.alu} = {2'b11, imm_u};
            opc_auipc:  {e.reg_write, e.use_alu, e.alu} = {2'b11, pc + imm_u};
            default:    e.illegal = 1'b1;
        endcase
        return e;
    endfunction

    // Follows what the pipeline register should hold
    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            live <= 1'b0;
        end else if (flush_i || !stall_i) begin
            live       <= valid_i && !flush_i;
            live_instr <= instr_i;
            live_pc    <= pc_i;
        end
    end

    always @(negedge clk) begin : compare
        expect_t e;
        if (arst_n_i && live) begin
            e = ref_execute(live_instr, live_pc, shadow);
            check("branch_taken_o", 32'(e.taken), 32'(branch_taken_o));
            check("reg_write_o", 32'(e.reg_write), 32'(reg_write_o));
            check("mem_write_o", 32'(e.mem_write), 32'(mem_write_o));
            check("illegal_o", 32'(e.illegal), 32'(illegal_o));
            if (!e.illegal) begin
                check("result_src_o", 32'(e.res_src), 32'(result_src_o));
                check("byte_op_o", 32'(e.byte_op), 32'(byte_op_o));
            end
            if (e.use_alu) check("alu_result_o", e.alu, alu_result_o);
            if (e.use_target) check("target_o", e.target, target_o);
            if (e.reg_write) check("rd_o", 32'(e.rd), 32'(rd_o));
            if (e.mem_write) check("store_data_o", e.store_data, store_data_o);
        end else if (arst_n_i) begin  // Bubble
            check("reg_write_o", 32'd0, 32'(reg_write_o));
            check("mem_write_o", 32'd0, 32'(mem_write_o));
            check("branch_taken_o", 32'd0, 32'(branch_taken_o));
            check("illegal_o", 32'd0, 32'(illegal_o));
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("Timeout, the run did not finish within %0d cycles", timeout_cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] pick_value();
        case ($urandom % 10)
            0: return 32'h0000_0000;
            1: return 32'h0000_0001;
            2: return 32'hffff_ffff;
            3: return 32'h8000_0000;
            4: return 32'h7fff_ffff;
            5: return 32'h0000_001f;
            6: return 32'h0000_0020;
            default: return $urandom;
        endcase
    endfunction

    task automatic write_reg(input logic [4:0] idx, input logic [31:0] val);
        @(posedge clk);
        valid_i   <= 1'b0;
        wb_we_i   <= 1'b1;
        wb_rd_i   <= idx;
        wb_data_i <= val;
        if (idx != 5'd0) shadow[idx] = val;
    endtask

    task automatic issue(input logic [31:0] instr, input logic [31:0] pc);
        @(posedge clk);
        instr_i <= instr;
        pc_i    <= pc;
        valid_i <= 1'b1;
        wb_we_i <= 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            valid_i <= 1'b0;
            wb_we_i <= 1'b0;
            stall_i <= 1'b0;
            flush_i <= 1'b0;
        end
    endtask

    task automatic alu_test();
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [31:0] instr;
        rs1 = 5'($urandom);
        rs2 = 5'($urandom);
        rd  = 5'($urandom);
        f3  = 3'($urandom);
        write_reg(rs1, pick_value());
        write_reg(rs2, pick_value());
        if ($urandom % 2 == 0) begin
            f7    = ((f3 == 3'b000 || f3 == 3'b101) && $urandom % 2 == 1) ? 7'h20 : 7'h00;
            instr = {f7, rs2, rs1, f3, rd, opc_op};
        end else begin
            imm = 12'($urandom);
            if (f3 == 3'b001) imm = {7'h00, imm[4:0]};  // Shift amounts only
            else if (f3 == 3'b101) imm = {(imm[11] ? 7'h20 : 7'h00), imm[4:0]};
            instr = {imm, rs1, f3, rd, opc_op_imm};
        end
        issue(instr, $urandom & 32'hffff_fffc);
    endtask

    task automatic ctrl_test();
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [12:0] boff;
        logic [20:0] joff;
        logic [11:0] imm;
        logic [31:0] instr;
        rs1  = 5'($urandom);
        rs2  = ($urandom % 4 == 0) ? rs1 : 5'($urandom);  // Equal operands now and then
        rd   = 5'($urandom);
        f3   = 3'($urandom);
        imm  = 12'($urandom);
        boff = 13'($urandom) & ~13'd1;
        joff = 21'($urandom) & ~21'd1;
        write_reg(rs1, pick_value());
        write_reg(rs2, pick_value());
        case ($urandom % 6)
            0: instr = {joff[20], joff[10:1], joff[11], joff[19:12], rd, opc_jal};
            1: instr = {imm, rs1, 3'b000, rd, opc_jalr};
            2: instr = {imm[11:5], rs2, rs1, 3'(f3 % 3), imm[4:0], opc_store};  // sb, sh or sw
            default: begin
                if (f3 == 3'b010 || f3 == 3'b011) f3[2] = 1'b1;
                instr = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], opc_branch};
            end
        endcase
        issue(instr, $urandom & 32'hffff_fffc);
    endtask

    initial begin
        void'($urandom(32'h544));
        clk       = 1'b0;
        arst_n_i  = 1'b0;
        instr_i   = '0;
        pc_i      = '0;
        valid_i   = 1'b0;
        stall_i   = 1'b0;
        flush_i   = 1'b0;
        wb_we_i   = 1'b0;
        wb_rd_i   = '0;
        wb_data_i = '0;
        for (int i = 0; i < 32; i++) shadow[i] = '0;
        repeat (10) @(posedge clk);
        arst_n_i <= 1'b1;
        idle(3);

        write_reg(5'd0, 32'hdead_beef);  // x0 stays zero
        issue({7'h00, 5'd0, 5'd0, 3'b000, 5'd3, opc_op}, 32'h0000_0100);
        issue({12'd5, 5'd0, 3'b000, 5'd0, opc_op_imm}, 32'h0000_0104);
        repeat (n_alu) alu_test();
        issue({20'h12345, 5'd4, opc_lui}, 32'h0000_0108);
        issue({20'hfffff, 5'd5, opc_auipc}, 32'h0000_010c);
        issue({12'hff0, 5'd7, 3'b010, 5'd8, opc_load}, 32'h0000_0110);
        repeat (n_ctrl) ctrl_test();

        // Writeback to x10 lands while the add sits in execute
        write_reg(5'd10, 32'h0000_1000);
        write_reg(5'd11, 32'h0000_0234);
        issue({7'h00, 5'd11, 5'd10, 3'b000, 5'd12, opc_op}, 32'h0000_0200);
        write_reg(5'd10, 32'h5000_0000);
        idle(2);

        issue({7'h00, 5'd11, 5'd10, 3'b000, 5'd13, opc_op}, 32'h0000_0204);
        @(posedge clk);
        instr_i <= {7'h20, 5'd11, 5'd10, 3'b000, 5'd14, opc_op};
        pc_i    <= 32'h0000_0208;
        stall_i <= 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check("alu_result_o", 32'h5000_0234, alu_result_o);  // Still the add of x10 and x11
        @(posedge clk);
        stall_i <= 1'b0;
        idle(2);

        @(posedge clk);
        instr_i <= {1'b0, 10'd8, 1'b0, 8'd0, 5'd1, opc_jal};  // jal x1, +16
        pc_i    <= 32'h0000_0300;
        valid_i <= 1'b1;
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        @(posedge clk);
        stall_i <= 1'b1;  // Flush wins over stall
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        stall_i <= 1'b0;
        valid_i <= 1'b0;
        idle(2);

        issue(32'hffff_ffff, 32'h0000_0400);
        issue(32'h0000_0000, 32'h0000_0404);
        idle(3);

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
